// File: core_region_pkg.sv
`default_nettype none

package core_region_pkg;

	// datapath widths
	localparam int WORD_W = 32;
	localparam int BE_W = 4;
	localparam int ADDR_W = 32;

	// on-chip data ram, in bytes
	localparam int DATA_RAM_BYTES = 2048;
	localparam int RAM_AW = $clog2(DATA_RAM_BYTES / BE_W);

	// addr[31:20] of the local data window
	localparam logic [11:0] LOCAL_WIN_HI = 12'h001;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BE_W-1:0] be_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// where the oldest outstanding lsu response comes from
	typedef enum logic {
		TGT_LOCAL,
		TGT_EXT
	} lsu_target_e;

	// four-phase bridge sequence
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_REQ,
		BR_RELEASE,
		BR_RESP
	} bridge_state_e;

endpackage

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram (
	input  wire                            clk,
	input  wire                            en_i,
	input  wire core_region_pkg::ram_addr_t addr_i,
	input  wire                            we_i,
	input  wire core_region_pkg::be_t      be_i,
	input  wire core_region_pkg::word_t    wdata_i,
	output core_region_pkg::word_t         rdata_o
);
	import core_region_pkg::*;

	localparam int DEPTH = 1 << RAM_AW;

	word_t mem [0:DEPTH-1];

	// byte lanes written only where enabled
	always_ff @(posedge clk) begin
		if (en_i && we_i) begin
			for (int i = 0; i < BE_W; i++) begin
				if (be_i[i]) begin
					mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
	end

	// registered read, old data on a write cycle
	always_ff @(posedge clk) begin
		if (en_i) begin
			rdata_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire

// File: data_mem_port.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem_port (
	input  wire                             clk,
	input  wire                             rst_n,

	input  wire                             host_req_i,
	input  wire core_region_pkg::ram_addr_t host_addr_i,
	input  wire                             host_we_i,
	input  wire core_region_pkg::be_t       host_be_i,
	input  wire core_region_pkg::word_t     host_wdata_i,
	output logic                            host_rvalid_o,
	output core_region_pkg::word_t          host_rdata_o,

	input  wire                             core_req_i,
	input  wire core_region_pkg::addr_t     core_addr_i,
	input  wire                             core_we_i,
	input  wire core_region_pkg::be_t       core_be_i,
	input  wire core_region_pkg::word_t     core_wdata_i,
	output logic                            core_gnt_o,
	output logic                            core_rvalid_o,
	output core_region_pkg::word_t          core_rdata_o
);
	import core_region_pkg::*;

	logic      ram_en;
	ram_addr_t ram_addr;
	logic      ram_we;
	be_t       ram_be;
	word_t     ram_wdata;
	word_t     ram_rdata;
	ram_addr_t core_word_addr;

	// byte address down to a word index inside the window
	assign core_word_addr = core_addr_i[RAM_AW+1:2];

	// host wins every cycle it asks
	assign core_gnt_o = core_req_i & ~host_req_i;

	assign ram_en = host_req_i | core_req_i;
	assign ram_addr = host_req_i ? host_addr_i : core_word_addr;
	assign ram_we = host_req_i ? host_we_i : core_we_i;
	assign ram_be = host_req_i ? host_be_i : core_be_i;
	assign ram_wdata = host_req_i ? host_wdata_i : core_wdata_i;

	data_ram u_data_ram (
		.clk     (clk),
		.en_i    (ram_en),
		.addr_i  (ram_addr),
		.we_i    (ram_we),
		.be_i    (ram_be),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	// owner of the ram in the previous cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			host_rvalid_o <= 1'b0;
			core_rvalid_o <= 1'b0;
		end else begin
			host_rvalid_o <= host_req_i;
			core_rvalid_o <= core_gnt_o;
		end
	end

	// both sides see the shared read port
	assign host_rdata_o = ram_rdata;
	assign core_rdata_o = ram_rdata;

endmodule

`default_nettype wire

// File: ext_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module ext_bus_bridge (
	input  wire                         clk,
	input  wire                         rst_n,

	input  wire                         req_i,
	input  wire core_region_pkg::addr_t addr_i,
	input  wire                         we_i,
	input  wire core_region_pkg::be_t   be_i,
	input  wire core_region_pkg::word_t wdata_i,
	output logic                        gnt_o,
	output logic                        rvalid_o,
	output core_region_pkg::word_t      rdata_o,

	output logic                        bus_req_o,
	output core_region_pkg::addr_t      bus_addr_o,
	output logic                        bus_we_o,
	output core_region_pkg::be_t        bus_be_o,
	output core_region_pkg::word_t      bus_wdata_o,
	input  wire                         bus_ack_i,
	input  wire core_region_pkg::word_t bus_rdata_i
);
	import core_region_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;

	addr_t addr_q;
	logic  we_q;
	be_t   be_q;
	word_t wdata_q;
	word_t rdata_q;

	// single outstanding access, so only idle accepts
	assign gnt_o = req_i && (state_q == BR_IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			BR_IDLE: begin
				if (req_i) begin
					state_d = BR_REQ;
				end
			end
			BR_REQ: begin
				if (bus_ack_i) begin
					state_d = BR_RELEASE;
				end
			end
			BR_RELEASE: begin
				// wait for the slave to drop ack
				if (!bus_ack_i) begin
					state_d = BR_RESP;
				end
			end
			BR_RESP: begin
				state_d = BR_IDLE;
			end
			default: begin
				state_d = BR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= BR_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// request fields, held until the access is done
	always_ff @(posedge clk) begin
		if (gnt_o) begin
			addr_q <= addr_i;
			we_q <= we_i;
			be_q <= be_i;
			wdata_q <= wdata_i;
		end
	end

	// slave data is only valid while ack is high
	always_ff @(posedge clk) begin
		if (state_q == BR_REQ && bus_ack_i) begin
			rdata_q <= bus_rdata_i;
		end
	end

	assign bus_req_o = (state_q == BR_REQ);
	assign bus_addr_o = addr_q;
	assign bus_we_o = we_q;
	assign bus_be_o = be_q;
	assign bus_wdata_o = wdata_q;

	assign rvalid_o = (state_q == BR_RESP);
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: lsu_router.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_router (
	input  wire                         clk,
	input  wire                         rst_n,

	input  wire                         lsu_req_i,
	input  wire core_region_pkg::addr_t lsu_addr_i,
	output logic                        lsu_gnt_o,
	output logic                        lsu_rvalid_o,
	output core_region_pkg::word_t      lsu_rdata_o,

	output logic                        loc_req_o,
	input  wire                         loc_gnt_i,
	input  wire                         loc_rvalid_i,
	input  wire core_region_pkg::word_t loc_rdata_i,

	output logic                        ext_req_o,
	input  wire                         ext_gnt_i,
	input  wire                         ext_rvalid_i,
	input  wire core_region_pkg::word_t ext_rdata_i
);
	import core_region_pkg::*;

	lsu_target_e tgt_req;
	lsu_target_e tgt_q;
	logic [1:0]  pend_q;
	logic [1:0]  pend_left;
	logic        blocked;

	// local window on the upper twelve address bits
	assign tgt_req = (lsu_addr_i[31:20] == LOCAL_WIN_HI) ? TGT_LOCAL : TGT_EXT;

	// responses still owed once this cycle's rvalid is taken
	assign pend_left = pend_q - {1'b0, lsu_rvalid_o};

	// no target switch until the other side has drained
	assign blocked = (pend_left != 2'd0) && (tgt_q != tgt_req);

	assign loc_req_o = lsu_req_i && !blocked && (tgt_req == TGT_LOCAL);
	assign ext_req_o = lsu_req_i && !blocked && (tgt_req == TGT_EXT);

	assign lsu_gnt_o = (tgt_req == TGT_LOCAL) ? loc_gnt_i : ext_gnt_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_q <= 2'd0;
			tgt_q <= TGT_LOCAL;
		end else begin
			pend_q <= pend_left + {1'b0, lsu_gnt_o};
			if (lsu_gnt_o) begin
				tgt_q <= tgt_req;
			end
		end
	end

	// only one side can have a response in flight
	assign lsu_rvalid_o = loc_rvalid_i | ext_rvalid_i;
	assign lsu_rdata_o = (tgt_q == TGT_EXT) ? ext_rdata_i : loc_rdata_i;

endmodule

`default_nettype wire

// File: core_mem_region.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_region (
	input  wire                             clk,
	input  wire                             rst_n,

	// load/store port
	input  wire                             lsu_req_i,
	input  wire core_region_pkg::addr_t     lsu_addr_i,
	input  wire                             lsu_we_i,
	input  wire core_region_pkg::be_t       lsu_be_i,
	input  wire core_region_pkg::word_t     lsu_wdata_i,
	output logic                            lsu_gnt_o,
	output logic                            lsu_rvalid_o,
	output core_region_pkg::word_t          lsu_rdata_o,

	// host word port into the data ram
	input  wire                             host_req_i,
	input  wire core_region_pkg::ram_addr_t host_addr_i,
	input  wire                             host_we_i,
	input  wire core_region_pkg::be_t       host_be_i,
	input  wire core_region_pkg::word_t     host_wdata_i,
	output logic                            host_rvalid_o,
	output core_region_pkg::word_t          host_rdata_o,

	// external req/ack bus
	output logic                            bus_req_o,
	output core_region_pkg::addr_t          bus_addr_o,
	output logic                            bus_we_o,
	output core_region_pkg::be_t            bus_be_o,
	output core_region_pkg::word_t          bus_wdata_o,
	input  wire                             bus_ack_i,
	input  wire core_region_pkg::word_t     bus_rdata_i
);
	import core_region_pkg::*;

	logic  loc_req;
	logic  loc_gnt;
	logic  loc_rvalid;
	word_t loc_rdata;

	logic  ext_req;
	logic  ext_gnt;
	logic  ext_rvalid;
	word_t ext_rdata;

	lsu_router u_lsu_router (
		.clk          (clk),
		.rst_n        (rst_n),
		.lsu_req_i    (lsu_req_i),
		.lsu_addr_i   (lsu_addr_i),
		.lsu_gnt_o    (lsu_gnt_o),
		.lsu_rvalid_o (lsu_rvalid_o),
		.lsu_rdata_o  (lsu_rdata_o),
		.loc_req_o    (loc_req),
		.loc_gnt_i    (loc_gnt),
		.loc_rvalid_i (loc_rvalid),
		.loc_rdata_i  (loc_rdata),
		.ext_req_o    (ext_req),
		.ext_gnt_i    (ext_gnt),
		.ext_rvalid_i (ext_rvalid),
		.ext_rdata_i  (ext_rdata)
	);

	// address and write fields fan out to both sides
	data_mem_port u_data_mem_port (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_req_i    (host_req_i),
		.host_addr_i   (host_addr_i),
		.host_we_i     (host_we_i),
		.host_be_i     (host_be_i),
		.host_wdata_i  (host_wdata_i),
		.host_rvalid_o (host_rvalid_o),
		.host_rdata_o  (host_rdata_o),
		.core_req_i    (loc_req),
		.core_addr_i   (lsu_addr_i),
		.core_we_i     (lsu_we_i),
		.core_be_i     (lsu_be_i),
		.core_wdata_i  (lsu_wdata_i),
		.core_gnt_o    (loc_gnt),
		.core_rvalid_o (loc_rvalid),
		.core_rdata_o  (loc_rdata)
	);

	ext_bus_bridge u_ext_bus_bridge (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (ext_req),
		.addr_i      (lsu_addr_i),
		.we_i        (lsu_we_i),
		.be_i        (lsu_be_i),
		.wdata_i     (lsu_wdata_i),
		.gnt_o       (ext_gnt),
		.rvalid_o    (ext_rvalid),
		.rdata_o     (ext_rdata),
		.bus_req_o   (bus_req_o),
		.bus_addr_o  (bus_addr_o),
		.bus_we_o    (bus_we_o),
		.bus_be_o    (bus_be_o),
		.bus_wdata_o (bus_wdata_o),
		.bus_ack_i   (bus_ack_i),
		.bus_rdata_i (bus_rdata_i)
	);

endmodule

`default_nettype wire

// File: tb_core_mem_region.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem_region;
	import core_region_pkg::*;

	localparam int N_TESTS = 6;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      lsu_req_i;
	addr_t     lsu_addr_i;
	logic      lsu_we_i;
	be_t       lsu_be_i;
	word_t     lsu_wdata_i;
	logic      lsu_gnt_o;
	logic      lsu_rvalid_o;
	word_t     lsu_rdata_o;
	logic      host_req_i;
	ram_addr_t host_addr_i;
	logic      host_we_i;
	be_t       host_be_i;
	word_t     host_wdata_i;
	logic      host_rvalid_o;
	word_t     host_rdata_o;
	logic      bus_req_o;
	addr_t     bus_addr_o;
	logic      bus_we_o;
	be_t       bus_be_o;
	word_t     bus_wdata_o;
	logic      bus_ack_i;
	word_t     bus_rdata_i;

	int          errors = 0;
	int          checks = 0;
	int          cyc = 0;
	logic [31:0] rng = 32'hdec9;
	logic        host_seen = 1'b0;

	// reference contents of the data ram and of the external memory
	word_t ram_model [0:(1<<RAM_AW)-1];
	word_t ext_mem [addr_t];

	word_t lsu_exp_q[$];
	bit    lsu_chk_q[$];
	int    lsu_due_q[$];
	word_t host_exp_q[$];
	bit    host_chk_q[$];
	addr_t bus_addr_q[$];
	bit    bus_we_q[$];
	be_t   bus_be_q[$];
	word_t bus_wdata_q[$];

	core_mem_region dut (
		.clk (clk), .rst_n (rst_n),
		.lsu_req_i (lsu_req_i), .lsu_addr_i (lsu_addr_i), .lsu_we_i (lsu_we_i),
		.lsu_be_i (lsu_be_i), .lsu_wdata_i (lsu_wdata_i), .lsu_gnt_o (lsu_gnt_o),
		.lsu_rvalid_o (lsu_rvalid_o), .lsu_rdata_o (lsu_rdata_o),
		.host_req_i (host_req_i), .host_addr_i (host_addr_i), .host_we_i (host_we_i),
		.host_be_i (host_be_i), .host_wdata_i (host_wdata_i),
		.host_rvalid_o (host_rvalid_o), .host_rdata_o (host_rdata_o),
		.bus_req_o (bus_req_o), .bus_addr_o (bus_addr_o), .bus_we_o (bus_we_o),
		.bus_be_o (bus_be_o), .bus_wdata_o (bus_wdata_o),
		.bus_ack_i (bus_ack_i), .bus_rdata_i (bus_rdata_i)
	);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wdata, input be_t be);
		word_t res;
		res = old;
		for (int i = 0; i < BE_W; i++) begin
			if (be[i]) begin
				res[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		return res;
	endfunction

	// unwritten external words read back a pattern of their address
	function automatic word_t ext_read(input addr_t addr);
		addr_t key;
		key = {addr[ADDR_W-1:2], 2'b00};
		if (ext_mem.exists(key)) begin
			return ext_mem[key];
		end
		return {key[15:0], key[31:16]} ^ 32'h5ac3_96e1;
	endfunction

	initial begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		host_seen <= host_req_i;
	end

	// host response one cycle after every host request
	always @(negedge clk) begin
		check_bit("host_rvalid_o", host_rvalid_o, host_seen);
		if (host_seen && host_exp_q.size() != 0) begin
			if (host_chk_q.pop_front()) begin
				check_word("host_rdata_o", host_rdata_o, host_exp_q[0]);
			end
			void'(host_exp_q.pop_front());
		end
	end

	// load/store responses in grant order
	always @(negedge clk) begin
		if (lsu_rvalid_o) begin
			if (lsu_exp_q.size() == 0) begin
				errors++;
				$display("a load/store response arrived with no access outstanding");
			end else begin
				if (lsu_due_q[0] >= 0) begin
					check_bit("lsu_rvalid_o one cycle after grant", cyc == lsu_due_q[0], 1'b1);
				end
				if (lsu_chk_q[0]) begin
					check_word("lsu_rdata_o", lsu_rdata_o, lsu_exp_q[0]);
				end
				void'(lsu_exp_q.pop_front());
				void'(lsu_chk_q.pop_front());
				void'(lsu_due_q.pop_front());
			end
		end
	end

	// bus slave model with a random ack delay
	initial begin
		int    delay;
		addr_t key;
		bus_ack_i = 1'b0;
		bus_rdata_i = '0;
		forever begin
			@(negedge clk);
			if (bus_req_o && !bus_ack_i) begin
				if (bus_addr_q.size() == 0) begin
					errors++;
					$display("the bus was requested without a granted external access");
				end else begin
					check_addr("bus_addr_o", bus_addr_o, bus_addr_q.pop_front());
					check_bit("bus_we_o", bus_we_o, bus_we_q.pop_front());
					check_word("bus_be_o", word_t'(bus_be_o), word_t'(bus_be_q.pop_front()));
					check_word("bus_wdata_o", bus_wdata_o, bus_wdata_q.pop_front());
				end
				rng = xorshift32(rng);
				delay = 1 + int'(rng % 32'd4);
				repeat (delay) @(negedge clk);
				key = {bus_addr_o[ADDR_W-1:2], 2'b00};
				if (bus_we_o) begin
					ext_mem[key] = merge_bytes(ext_read(key), bus_wdata_o, bus_be_o);
				end
				bus_rdata_i = ext_read(key);
				bus_ack_i = 1'b1;
				while (bus_req_o) begin
					@(negedge clk);
				end
				bus_ack_i = 1'b0;
			end
		end
	end

	task automatic host_op(input ram_addr_t addr, input logic we, input be_t be,
			input word_t wdata);
		@(negedge clk);
		host_req_i = 1'b1;
		host_addr_i = addr;
		host_we_i = we;
		host_be_i = be;
		host_wdata_i = wdata;
		host_exp_q.push_back(ram_model[addr]);
		host_chk_q.push_back(!we);
		if (we) begin
			ram_model[addr] = merge_bytes(ram_model[addr], wdata, be);
		end
	endtask

	task automatic host_idle();
		@(negedge clk);
		host_req_i = 1'b0;
	endtask

	// hold the request until granted, then record what the grant implies
	task automatic lsu_wait_grant(input addr_t addr, input logic we, input be_t be,
			input word_t wdata);
		int idx;
		while (!lsu_gnt_o) begin
			@(negedge clk);
			#1;
		end
		idx = int'(addr[RAM_AW+1:2]);
		lsu_chk_q.push_back(!we);
		if (addr[31:20] == LOCAL_WIN_HI) begin
			lsu_exp_q.push_back(ram_model[idx]);
			lsu_due_q.push_back(cyc + 1);
			if (we) begin
				ram_model[idx] = merge_bytes(ram_model[idx], wdata, be);
			end
		end else begin
			lsu_exp_q.push_back(ext_read(addr));
			lsu_due_q.push_back(-1);
			bus_addr_q.push_back(addr);
			bus_we_q.push_back(we);
			bus_be_q.push_back(be);
			bus_wdata_q.push_back(wdata);
		end
	endtask

	task automatic lsu_issue(input addr_t addr, input logic we, input be_t be,
			input word_t wdata);
		@(negedge clk);
		lsu_req_i = 1'b1;
		lsu_addr_i = addr;
		lsu_we_i = we;
		lsu_be_i = be;
		lsu_wdata_i = wdata;
		#1;
		lsu_wait_grant(addr, we, be, wdata);
	endtask

	task automatic lsu_drain();
		@(negedge clk);
		lsu_req_i = 1'b0;
		while (lsu_exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic reset_state();
		check_bit("lsu_gnt_o", lsu_gnt_o, 1'b0);
		check_bit("lsu_rvalid_o", lsu_rvalid_o, 1'b0);
		check_bit("host_rvalid_o", host_rvalid_o, 1'b0);
		check_bit("bus_req_o", bus_req_o, 1'b0);
		check_bit("bridge in BR_IDLE", dut.u_ext_bus_bridge.state_q == BR_IDLE, 1'b1);
	endtask

	task automatic host_byte_merge();
		for (int i = 0; i < 8; i++) begin
			host_op(ram_addr_t'(i), 1'b1, 4'hf, 32'h1100_0000 + i * 32'h0101);
		end
		for (int i = 0; i < 8; i++) begin
			host_op(ram_addr_t'(i), 1'b1, be_t'(i + 5), 32'hcafe_0000 + i);
		end
		for (int i = 0; i < 8; i++) begin
			host_op(ram_addr_t'(i), 1'b0, 4'hf, '0);
		end
		host_idle();
	endtask

	task automatic core_local_access();
		for (int i = 0; i < 8; i++) begin
			host_op(ram_addr_t'(16 + i), 1'b1, 4'hf, 32'h7700_0000 ^ (i * 32'h0003_0405));
		end
		host_idle();
		for (int i = 0; i < 8; i++) begin
			lsu_issue(32'h0010_0040 + i * 4, 1'b0, 4'hf, '0);
		end
		for (int i = 0; i < 4; i++) begin
			lsu_issue(32'h0010_0040 + i * 4, 1'b1, be_t'(4'h9 >> i), 32'hbead_0000 + i);
		end
		lsu_drain();
		for (int i = 0; i < 4; i++) begin
			host_op(ram_addr_t'(16 + i), 1'b0, 4'hf, '0);
		end
		host_idle();
	endtask

	task automatic core_external_access();
		for (int i = 0; i < 3; i++) begin
			lsu_issue(32'h8000_0100 + i * 4, 1'b0, 4'hf, '0);
		end
		for (int i = 0; i < 3; i++) begin
			lsu_issue(32'h8000_0200 + i * 4, 1'b1, 4'b0110, 32'h1234_5678 + i);
		end
		for (int i = 0; i < 3; i++) begin
			lsu_issue(32'h8000_0200 + i * 4, 1'b0, 4'hf, '0);
		end
		lsu_drain();
	endtask

	task automatic host_priority();
		for (int k = 0; k < 4; k++) begin
			host_op(ram_addr_t'(60 + k), 1'b1, 4'hf, 32'h0bad_f000 + k);
			if (k == 0) begin
				lsu_req_i = 1'b1;
				lsu_addr_i = 32'h0010_0000 + 61 * 4;
				lsu_we_i = 1'b0;
				lsu_be_i = 4'hf;
				lsu_wdata_i = '0;
			end
			#1;
			check_bit("lsu_gnt_o while host requests", lsu_gnt_o, 1'b0);
		end
		@(negedge clk);
		host_req_i = 1'b0;
		#1;
		lsu_wait_grant(32'h0010_0000 + 61 * 4, 1'b0, 4'hf, '0);
		lsu_drain();
	endtask

	task automatic mixed_targets();
		lsu_issue(32'h0010_0044, 1'b0, 4'hf, '0);
		lsu_issue(32'h8000_0204, 1'b0, 4'hf, '0);
		lsu_issue(32'h0010_0048, 1'b1, 4'b1100, 32'hfeed_beef);
		lsu_issue(32'h8000_0300, 1'b1, 4'b0011, 32'h5555_aaaa);
		lsu_issue(32'h0010_0048, 1'b0, 4'hf, '0);
		lsu_issue(32'h0010_0050, 1'b0, 4'hf, '0);
		lsu_issue(32'h8000_0300, 1'b0, 4'hf, '0);
		lsu_issue(32'h0010_00f4, 1'b0, 4'hf, '0);
		lsu_drain();
	endtask

	initial begin
		rst_n = 1'b0;
		lsu_req_i = 1'b0;
		lsu_addr_i = '0;
		lsu_we_i = 1'b0;
		lsu_be_i = '0;
		lsu_wdata_i = '0;
		host_req_i = 1'b0;
		host_addr_i = '0;
		host_we_i = 1'b0;
		host_be_i = '0;
		host_wdata_i = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		reset_state();
		host_byte_merge();
		core_local_access();
		core_external_access();
		host_priority();
		mixed_targets();
		repeat (4) @(negedge clk);
		if (bus_addr_q.size() != 0) begin
			errors++;
			$display("an external access never reached the bus");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (N_TESTS * 400) @(posedge clk);
		$display("the run timed out before all tests finished");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
core_region_pkg.sv
data_ram.sv
data_mem_port.sv
ext_bus_bridge.sv
lsu_router.sv
core_mem_region.sv
tb_core_mem_region.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
	--top-module tb_core_mem_region -o tb_core_mem_region
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_core_mem_region > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

exit 0
